/* hw/csr_pkg.sv */
package csr_pkg;

    typedef enum logic [13:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_addr_e;

    typedef enum logic [6:0] {
        EXC_INT, EXC_ADEF, EXC_ALE, EXC_SYS, EXC_BRK, EXC_INE,
        EXC_PIL, EXC_PIS, EXC_PIF, EXC_PME, EXC_PPI, EXC_TLBR
    } exc_cause_e;

    localparam logic [5:0] ECODE_TLBR = 6'h3f;  // estat ecode of a tlb refill

    typedef struct packed {
        logic        en;
        csr_addr_e   addr;
        logic [31:0] data;
    } csr_write_t;

    typedef struct packed {
        logic        valid;
        exc_cause_e  cause;
        logic [31:0] pc;
        logic [31:0] vaddr;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic        is_inst;  // fault on fetch
    } exc_req_t;

    // crmd[8:0], msb first
    typedef struct packed {
        logic [1:0] datm;
        logic [1:0] datf;
        logic       pg;
        logic       da;
        logic       ie;
        logic [1:0] plv;
    } crmd_t;

    typedef struct packed {
        logic [31:0] crmd;
        logic [31:0] prmd;
        logic [31:0] ecfg;
        logic [31:0] estat;
        logic [31:0] era;
        logic [31:0] badv;
        logic [31:0] eentry;
        logic [31:0] save0;
        logic [31:0] save1;
        logic [31:0] save2;
        logic [31:0] save3;
    } priv_view_t;

    typedef struct packed {
        logic [31:0] tid;
        logic [31:0] tcfg;
        logic [31:0] tval;
    } timer_view_t;

    typedef struct packed {
        priv_view_t  priv;
        timer_view_t timer;
    } csr_view_t;

    typedef struct packed {
        logic      en;
        csr_addr_e addr;
    } rd_req_t;

endpackage

/* hw/csr_priv_regs.sv */
`timescale 1ns/100ps

module csr_priv_regs import csr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  csr_write_t  wr_i,
    input  exc_req_t    exc_i,
    input  logic        ertn_i,
    input  logic [7:0]  hwi_i,
    input  logic        ipi_i,
    input  logic        timer_irq_i,
    output crmd_t       crmd_o,
    output logic [31:0] era_o,
    output logic [31:0] eentry_o,
    output logic        irq_o,
    output priv_view_t  view_o
);

    localparam crmd_t CRMD_RST = '{
        datm: 2'b00, datf: 2'b00, pg: 1'b0, da: 1'b1, ie: 1'b0, plv: 2'b00
    };
    localparam logic [12:0] ECFG_MASK = 13'h1bff;  // bit 10 reserved

    crmd_t       crmd_q;
    logic [2:0]  prmd_q;      // pie, pplv
    logic [12:0] ecfg_q;
    logic [1:0]  estat_is_q;  // software interrupt bits
    logic [7:0]  estat_hwi_q;
    logic        estat_ipi_q;
    logic [5:0]  ecode_q;
    logic [8:0]  esubcode_q;
    logic [31:0] era_q;
    logic [31:0] badv_q;
    logic [25:0] eentry_q;
    logic [31:0] save_q [4];

    logic [13:0] wr_addr;
    logic        crmd_wen;
    logic        prmd_wen;
    logic        ecfg_wen;
    logic        estat_wen;
    logic        era_wen;
    logic        badv_wen;
    logic        eentry_wen;
    logic        save_wen;
    logic        badv_upd;
    logic [31:0] badv_next;
    logic [31:0] estat;

    assign wr_addr    = wr_i.addr;
    assign crmd_wen   = wr_i.en && (wr_i.addr == CSR_CRMD);
    assign prmd_wen   = wr_i.en && (wr_i.addr == CSR_PRMD);
    assign ecfg_wen   = wr_i.en && (wr_i.addr == CSR_ECFG);
    assign estat_wen  = wr_i.en && (wr_i.addr == CSR_ESTAT);
    assign era_wen    = wr_i.en && (wr_i.addr == CSR_ERA);
    assign badv_wen   = wr_i.en && (wr_i.addr == CSR_BADV);
    assign eentry_wen = wr_i.en && (wr_i.addr == CSR_EENTRY);
    assign save_wen   = wr_i.en && (wr_i.addr >= CSR_SAVE0) && (wr_i.addr <= CSR_SAVE3);

    // which causes report a bad address
    always_comb begin
        badv_upd  = 1'b1;
        badv_next = exc_i.is_inst ? exc_i.pc : exc_i.vaddr;
        case (exc_i.cause)
            EXC_TLBR, EXC_ALE, EXC_PIL, EXC_PIS, EXC_PIF, EXC_PME, EXC_PPI: begin
                badv_upd = 1'b1;
            end
            EXC_ADEF: begin
                badv_next = exc_i.pc;
            end
            default: begin
                badv_upd = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_q <= CRMD_RST;
        end else if (exc_i.valid) begin
            crmd_q.plv <= 2'b00;
            crmd_q.ie  <= 1'b0;
            if (exc_i.cause == EXC_TLBR) begin
                crmd_q.da <= 1'b1;  // refill runs untranslated
                crmd_q.pg <= 1'b0;
            end
        end else if (ertn_i) begin
            crmd_q.plv <= prmd_q[1:0];
            crmd_q.ie  <= prmd_q[2];
            if (ecode_q == ECODE_TLBR) begin
                crmd_q.da <= 1'b0;
                crmd_q.pg <= 1'b1;
            end
        end else if (crmd_wen) begin
            crmd_q <= crmd_t'(wr_i.data[8:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_q     <= '0;
            ecfg_q     <= '0;
            estat_is_q <= '0;
            ecode_q    <= '0;
            esubcode_q <= '0;
            era_q      <= '0;
            badv_q     <= '0;
            eentry_q   <= '0;
        end else begin
            if (exc_i.valid) begin
                prmd_q     <= {crmd_q.ie, crmd_q.plv};
                ecode_q    <= exc_i.ecode;
                esubcode_q <= exc_i.esubcode;
                era_q      <= exc_i.pc;
                if (badv_upd) begin
                    badv_q <= badv_next;
                end
            end else begin
                if (prmd_wen) prmd_q <= wr_i.data[2:0];
                if (estat_wen) estat_is_q <= wr_i.data[1:0];
                if (era_wen) era_q <= wr_i.data;
                if (badv_wen) badv_q <= wr_i.data;
            end
            if (ecfg_wen) begin
                ecfg_q <= wr_i.data[12:0] & ECFG_MASK;
            end
            if (eentry_wen) begin
                eentry_q <= wr_i.data[31:6];
            end
        end
    end

    // interrupt lines, one cycle late
    always_ff @(posedge clk) begin
        if (rst) begin
            estat_hwi_q <= '0;
            estat_ipi_q <= 1'b0;
        end else begin
            estat_hwi_q <= hwi_i;
            estat_ipi_q <= ipi_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else if (save_wen) begin
            save_q[wr_addr[1:0]] <= wr_i.data;
        end
    end

    // timer flag lives in csr_timer, shown here as bit 11
    assign estat = {1'b0, esubcode_q, ecode_q, 3'b000, estat_ipi_q, timer_irq_i, 1'b0,
                    estat_hwi_q, estat_is_q};

    assign irq_o    = (|(ecfg_q & estat[12:0])) && crmd_q.ie;
    assign crmd_o   = crmd_q;
    assign era_o    = era_q;
    assign eentry_o = {eentry_q, 6'b0};

    assign view_o.crmd   = {23'b0, crmd_q};
    assign view_o.prmd   = {29'b0, prmd_q};
    assign view_o.ecfg   = {19'b0, ecfg_q};
    assign view_o.estat  = estat;
    assign view_o.era    = era_q;
    assign view_o.badv   = badv_q;
    assign view_o.eentry = {eentry_q, 6'b0};
    assign view_o.save0  = save_q[0];
    assign view_o.save1  = save_q[1];
    assign view_o.save2  = save_q[2];
    assign view_o.save3  = save_q[3];

    // control unit never raises an exception and a return together
    a_exc_ertn_excl: assert property (
        @(posedge clk) disable iff (rst) !(exc_i.valid && ertn_i)
    ) else $error("exception and ertn in the same cycle");

endmodule

/* hw/csr_timer.sv */
`timescale 1ns/100ps

module csr_timer import csr_pkg::*; #(
    parameter int TIMER_W = 32
) (
    input  logic        clk,
    input  logic        rst,
    input  csr_write_t  wr_i,
    output logic        timer_irq_o,
    output timer_view_t view_o
);

    logic [31:0]        tid_q;
    logic [31:0]        tcfg_q;
    logic [TIMER_W-1:0] tval_q;
    logic               timer_en_q;
    logic               irq_q;

    logic tid_wen;
    logic tcfg_wen;
    logic ticlr_wen;
    logic expire;

    assign tid_wen   = wr_i.en && (wr_i.addr == CSR_TID);
    assign tcfg_wen  = wr_i.en && (wr_i.addr == CSR_TCFG);
    assign ticlr_wen = wr_i.en && (wr_i.addr == CSR_TICLR);

    assign expire = timer_en_q && (tval_q == '0) && !tcfg_wen;

    always_ff @(posedge clk) begin
        if (rst) begin
            tid_q <= '0;
        end else if (tid_wen) begin
            tid_q <= wr_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg_q     <= '0;
            tval_q     <= '0;
            timer_en_q <= 1'b0;
        end else if (tcfg_wen) begin
            tcfg_q     <= wr_i.data;
            tval_q     <= {wr_i.data[TIMER_W-1:2], 2'b00};
            timer_en_q <= wr_i.data[0];
        end else if (timer_en_q) begin
            if (tval_q != '0) begin
                tval_q <= tval_q - 1'b1;
            end else begin
                // periodic reloads, one-shot parks at all ones
                tval_q     <= tcfg_q[1] ? {tcfg_q[TIMER_W-1:2], 2'b00} : '1;
                timer_en_q <= tcfg_q[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_q <= 1'b0;
        end else if (ticlr_wen && wr_i.data[0]) begin
            irq_q <= 1'b0;  // clear wins
        end else if (expire) begin
            irq_q <= 1'b1;
        end
    end

    assign timer_irq_o = irq_q;

    assign view_o.tid  = tid_q;
    assign view_o.tcfg = tcfg_q;
    assign view_o.tval = 32'(tval_q);

    // a stopped timer keeps its count until software rearms it
    a_tval_hold: assert property (
        @(posedge clk) disable iff (rst)
        (!timer_en_q && !tcfg_wen) |=> $stable(tval_q)
    ) else $error("tval moved while timer disabled");

endmodule

/* hw/csr_read_port.sv */
`timescale 1ns/100ps

module csr_read_port import csr_pkg::*; (
    input  rd_req_t     req_i,
    input  csr_view_t   view_i,
    output logic [31:0] data_o
);

    always_comb begin
        data_o = '0;
        if (req_i.en) begin
            case (req_i.addr)
                CSR_CRMD: begin
                    data_o = view_i.priv.crmd;
                end
                CSR_PRMD: begin
                    data_o = view_i.priv.prmd;
                end
                CSR_ECFG: begin
                    data_o = view_i.priv.ecfg;
                end
                CSR_ESTAT: begin
                    data_o = view_i.priv.estat;
                end
                CSR_ERA: begin
                    data_o = view_i.priv.era;
                end
                CSR_BADV: begin
                    data_o = view_i.priv.badv;
                end
                CSR_EENTRY: begin
                    data_o = view_i.priv.eentry;
                end
                CSR_SAVE0: begin
                    data_o = view_i.priv.save0;
                end
                CSR_SAVE1: begin
                    data_o = view_i.priv.save1;
                end
                CSR_SAVE2: begin
                    data_o = view_i.priv.save2;
                end
                CSR_SAVE3: begin
                    data_o = view_i.priv.save3;
                end
                CSR_TID: begin
                    data_o = view_i.timer.tid;
                end
                CSR_TCFG: begin
                    data_o = view_i.timer.tcfg;
                end
                CSR_TVAL: begin
                    data_o = view_i.timer.tval;
                end
                CSR_TICLR: begin
                    data_o = '0;  // write-only
                end
                default: begin
                    data_o = '0;
                end
            endcase
        end
    end

endmodule

/* hw/csr_top.sv */
`timescale 1ns/100ps

module csr_top import csr_pkg::*; #(
    parameter int TIMER_W = 32
) (
    input  logic        clk,
    input  logic        rst,
    input  csr_write_t  wr_i,
    input  exc_req_t    exc_i,
    input  logic        ertn_i,
    input  logic [7:0]  hwi_i,
    input  logic        ipi_i,
    input  rd_req_t     rd0_i,
    input  rd_req_t     rd1_i,
    output logic [31:0] rd0_data_o,
    output logic [31:0] rd1_data_o,
    output crmd_t       crmd_o,
    output logic [31:0] era_o,
    output logic [31:0] eentry_o,
    output logic        irq_o
);

    priv_view_t  priv_view;
    timer_view_t timer_view;
    csr_view_t   view;
    logic        timer_irq;

    assign view = '{priv: priv_view, timer: timer_view};

    csr_priv_regs u_priv_regs (
        .clk         (clk),
        .rst         (rst),
        .wr_i        (wr_i),
        .exc_i       (exc_i),
        .ertn_i      (ertn_i),
        .hwi_i       (hwi_i),
        .ipi_i       (ipi_i),
        .timer_irq_i (timer_irq),
        .crmd_o      (crmd_o),
        .era_o       (era_o),
        .eentry_o    (eentry_o),
        .irq_o       (irq_o),
        .view_o      (priv_view)
    );

    csr_timer #(
        .TIMER_W (TIMER_W)
    ) u_timer (
        .clk         (clk),
        .rst         (rst),
        .wr_i        (wr_i),
        .timer_irq_o (timer_irq),
        .view_o      (timer_view)
    );

    // dispatch slot 0
    csr_read_port u_rd_port0 (
        .req_i  (rd0_i),
        .view_i (view),
        .data_o (rd0_data_o)
    );

    // dispatch slot 1
    csr_read_port u_rd_port1 (
        .req_i  (rd1_i),
        .view_i (view),
        .data_o (rd1_data_o)
    );

endmodule

/* tb/csr_tb.sv */
`timescale 1ns/100ps

module csr_tb import csr_pkg::*;;

    localparam int N_WR  = 60;
    localparam int N_EXC = 30;
    localparam int N_RET = 30;
    localparam int N_IRQ = 40;
    localparam int C_MAX = 9;
    localparam int MAX_CYCLES = 10 + 4 * N_WR + 8 * N_EXC + 8 * N_RET + 16 * C_MAX + 40
                                + 8 * N_IRQ + 100;

    logic        clk;
    logic        rst;
    csr_write_t  wr_i;
    exc_req_t    exc_i;
    logic        ertn_i;
    logic [7:0]  hwi_i;
    logic        ipi_i;
    rd_req_t     rd0_i;
    rd_req_t     rd1_i;
    logic [31:0] rd0_data_o;
    logic [31:0] rd1_data_o;
    crmd_t       crmd_o;
    logic [31:0] era_o;
    logic [31:0] eentry_o;
    logic        irq_o;

    // reference model state
    logic [8:0]  m_crmd;  // datm datf pg da ie plv
    logic [2:0]  m_prmd;
    logic [12:0] m_ecfg;
    logic [1:0]  m_is;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    logic [31:0] m_era;
    logic [31:0] m_badv;
    logic [25:0] m_eentry;
    logic [31:0] m_save [4];
    logic [31:0] m_tid;
    logic [31:0] m_tcfg;
    logic [31:0] m_tval;
    logic        m_ten;
    logic        m_tirq;
    logic [7:0]  m_hwi;
    logic        m_ipi;
    logic [31:0] m_estat;
    logic        m_irq;
    logic        tcfg_wr;
    logic        ticlr_wr;

    logic [31:0] rng_state = 32'd50;
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;

    csr_top #(.TIMER_W(32)) UUT (
        .clk(clk), .rst(rst), .wr_i(wr_i), .exc_i(exc_i), .ertn_i(ertn_i),
        .hwi_i(hwi_i), .ipi_i(ipi_i), .rd0_i(rd0_i), .rd1_i(rd1_i),
        .rd0_data_o(rd0_data_o), .rd1_data_o(rd1_data_o), .crmd_o(crmd_o),
        .era_o(era_o), .eentry_o(eentry_o), .irq_o(irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic csr_addr_e pick_addr(input int idx);
        case (idx)
            0: return CSR_CRMD;
            1: return CSR_PRMD;
            2: return CSR_ECFG;
            3: return CSR_ESTAT;
            4: return CSR_ERA;
            5: return CSR_BADV;
            6: return CSR_EENTRY;
            7: return CSR_SAVE0;
            8: return CSR_SAVE1;
            9: return CSR_SAVE2;
            10: return CSR_SAVE3;
            11: return CSR_TID;
            12: return CSR_TCFG;
            13: return CSR_TVAL;
            14: return CSR_TICLR;
            default: return csr_addr_e'(14'h010);  // not implemented
        endcase
    endfunction

    assign tcfg_wr  = wr_i.en && (wr_i.addr == CSR_TCFG);
    assign ticlr_wr = wr_i.en && (wr_i.addr == CSR_TICLR) && wr_i.data[0];
    assign m_estat  = {1'b0, m_esub, m_ecode, 3'b000, m_ipi, m_tirq, 1'b0, m_hwi, m_is};
    assign m_irq    = (|(m_ecfg & m_estat[12:0])) && m_crmd[2];

    always @(posedge clk) begin
        if (rst) begin
            m_crmd <= 9'h008;
            m_prmd <= '0;
            m_ecfg <= '0;
            m_is <= '0;
            m_ecode <= '0;
            m_esub <= '0;
            m_era <= '0;
            m_badv <= '0;
            m_eentry <= '0;
            for (int i = 0; i < 4; i++) m_save[i] <= '0;
            m_tid <= '0;
            m_tcfg <= '0;
            m_tval <= '0;
            m_ten <= 1'b0;
            m_tirq <= 1'b0;
            m_hwi <= '0;
            m_ipi <= 1'b0;
        end else begin
            if (exc_i.valid) begin
                m_crmd[2:0] <= 3'b000;
                if (exc_i.cause == EXC_TLBR) m_crmd[4:3] <= 2'b01;  // direct mode
                m_prmd <= m_crmd[2:0];
                m_ecode <= exc_i.ecode;
                m_esub <= exc_i.esubcode;
                m_era <= exc_i.pc;
                if (exc_i.cause inside {EXC_TLBR, EXC_ALE, EXC_PIL, EXC_PIS, EXC_PIF,
                                        EXC_PME, EXC_PPI})
                    m_badv <= exc_i.is_inst ? exc_i.pc : exc_i.vaddr;
                else if (exc_i.cause == EXC_ADEF)
                    m_badv <= exc_i.pc;
            end else if (ertn_i) begin
                m_crmd[2:0] <= m_prmd;
                if (m_ecode == 6'h3f) m_crmd[4:3] <= 2'b10;  // back to paged
            end else if (wr_i.en && wr_i.addr == CSR_CRMD) begin
                m_crmd <= wr_i.data[8:0];
            end
            // exception entry owns these
            if (wr_i.en && !exc_i.valid) begin
                case (wr_i.addr)
                    CSR_PRMD: m_prmd <= wr_i.data[2:0];
                    CSR_ESTAT: m_is <= wr_i.data[1:0];
                    CSR_ERA: m_era <= wr_i.data;
                    CSR_BADV: m_badv <= wr_i.data;
                    default: ;
                endcase
            end
            if (wr_i.en) begin
                case (wr_i.addr)
                    CSR_ECFG: m_ecfg <= wr_i.data[12:0] & 13'h1bff;
                    CSR_EENTRY: m_eentry <= wr_i.data[31:6];
                    CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: begin
                        m_save[wr_i.addr[1:0]] <= wr_i.data;
                    end
                    CSR_TID: m_tid <= wr_i.data;
                    default: ;
                endcase
            end
            if (tcfg_wr) begin
                m_tcfg <= wr_i.data;
                m_tval <= {wr_i.data[31:2], 2'b00};
                m_ten <= wr_i.data[0];
            end else if (m_ten) begin
                if (m_tval != 0) begin
                    m_tval <= m_tval - 1;
                end else begin
                    m_tval <= m_tcfg[1] ? {m_tcfg[31:2], 2'b00} : 32'hffff_ffff;
                    m_ten <= m_tcfg[1];
                end
            end
            if (ticlr_wr) m_tirq <= 1'b0;
            else if (m_ten && m_tval == 0 && !tcfg_wr) m_tirq <= 1'b1;
            m_hwi <= hwi_i;
            m_ipi <= ipi_i;
        end
    end

    function automatic logic [31:0] model_read(input rd_req_t r);
        if (!r.en) return '0;
        case (r.addr)
            CSR_CRMD: return {23'b0, m_crmd};
            CSR_PRMD: return {29'b0, m_prmd};
            CSR_ECFG: return {19'b0, m_ecfg};
            CSR_ESTAT: return m_estat;
            CSR_ERA: return m_era;
            CSR_BADV: return m_badv;
            CSR_EENTRY: return {m_eentry, 6'b0};
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: return m_save[r.addr[1:0]];
            CSR_TID: return m_tid;
            CSR_TCFG: return m_tcfg;
            CSR_TVAL: return m_tval;
            default: return '0;
        endcase
    endfunction

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // outputs settle between edges
    always @(negedge clk) begin
        if (!rst) begin
            check_val("rd0 data", rd0_data_o, model_read(rd0_i));
            check_val("rd1 data", rd1_data_o, model_read(rd1_i));
            check_val("crmd_o", {23'b0, crmd_o}, {23'b0, m_crmd});
            check_val("era_o", era_o, m_era);
            check_val("eentry_o", eentry_o, {m_eentry, 6'b0});
            check_val("irq_o", {31'b0, irq_o}, {31'b0, m_irq});
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic write_csr(input csr_addr_e a, input logic [31:0] d);
        @(posedge clk);
        wr_i <= '{en: 1'b1, addr: a, data: d};
        @(posedge clk);
        wr_i.en <= 1'b0;
    endtask

    task automatic read_pair(input csr_addr_e a0, input csr_addr_e a1, input logic en1);
        @(posedge clk);
        rd0_i <= '{en: 1'b1, addr: a0};
        rd1_i <= '{en: en1, addr: a1};
        @(negedge clk);
    endtask

    task automatic raise_exc(input logic tlbr);
        exc_cause_e c;
        logic [31:0] r;
        r = next_rand();
        c = tlbr ? EXC_TLBR : exc_cause_e'(r % 12);
        @(posedge clk);
        exc_i <= '{valid: 1'b1, cause: c, pc: next_rand(), vaddr: next_rand(),
                   ecode: (c == EXC_TLBR) ? ECODE_TLBR : r[13:8], esubcode: r[22:14],
                   is_inst: r[31]};
        @(posedge clk);
        exc_i.valid <= 1'b0;
    endtask

    // edges from the last sample until the timer flag shows in estat
    task automatic wait_flag(output int n);
        logic found;
        n = 0;
        found = 1'b0;
        while (!found && n < 4 * C_MAX + 8) begin
            @(negedge clk);
            if (rd0_data_o[11]) begin
                found = 1'b1;
            end else begin
                @(posedge clk);
                n++;
            end
        end
        checks++;
        if (!found) begin
            errors++;
            $display("Timer flag was never set within %0d cycles", n);
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        $display("test %s finished with %0d errors", name, errors - err_before);
    endtask

    initial begin
        int e0;
        int n;
        int c;
        logic [31:0] r;
        rst <= 1'b1;
        wr_i <= '0;
        exc_i <= '0;
        ertn_i <= 1'b0;
        hwi_i <= '0;
        ipi_i <= 1'b0;
        rd0_i <= '0;
        rd1_i <= '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        e0 = errors;
        for (int i = 0; i < N_WR; i++) begin
            r = next_rand();
            write_csr(pick_addr(r % 15), next_rand());
            read_pair(pick_addr(r % 15), pick_addr(r % 15), r[20]);
            read_pair(pick_addr(15), pick_addr(r % 15), 1'b0);  // unknown and disabled
        end
        end_test("register writes", e0);

        e0 = errors;
        for (int i = 0; i < N_EXC; i++) begin
            write_csr(CSR_CRMD, next_rand());
            raise_exc(1'b0);
            read_pair(CSR_CRMD, CSR_PRMD, 1'b1);
            read_pair(CSR_ERA, CSR_BADV, 1'b1);
            read_pair(CSR_ESTAT, CSR_BADV, 1'b1);
        end
        end_test("exception entry", e0);

        e0 = errors;
        for (int i = 0; i < N_RET; i++) begin
            write_csr(CSR_CRMD, next_rand());
            raise_exc(i[0]);
            @(posedge clk);
            ertn_i <= 1'b1;
            @(posedge clk);
            ertn_i <= 1'b0;
            read_pair(CSR_CRMD, CSR_PRMD, 1'b1);
        end
        end_test("exception return", e0);

        e0 = errors;
        write_csr(CSR_TCFG, 32'h0);
        write_csr(CSR_TICLR, 32'h1);
        c = 2 + next_rand() % (C_MAX - 1);
        read_pair(CSR_ESTAT, CSR_TVAL, 1'b1);
        write_csr(CSR_TCFG, 32'(c * 4 + 1));
        wait_flag(n);
        checks++;
        if (n != 4 * c + 1) begin
            errors++;
            $display("Error at %0t: one-shot flag after %0d edges, expected %0d",
                     $time, n, 4 * c + 1);
        end
        write_csr(CSR_TICLR, 32'h1);
        repeat (3) @(negedge clk);
        checks++;
        if (rd0_data_o[11] !== 1'b0 || rd1_data_o !== 32'hffff_ffff) begin
            errors++;
            $display("Error at %0t: one-shot timer did not stop after clear", $time);
        end
        end_test("one-shot timer", e0);

        e0 = errors;
        c = 2 + next_rand() % (C_MAX - 1);
        write_csr(CSR_TCFG, 32'(c * 4 + 3));
        wait_flag(n);
        checks++;
        if (n != 4 * c + 1) begin
            errors++;
            $display("Error at %0t: periodic flag after %0d edges, expected %0d",
                     $time, n, 4 * c + 1);
        end
        write_csr(CSR_TICLR, 32'h1);
        wait_flag(n);
        checks++;
        if (n != 4 * c - 1) begin
            errors++;
            $display("Error at %0t: periodic reload interval off by %0d", $time, n - (4 * c - 1));
        end
        write_csr(CSR_TCFG, 32'h0);
        write_csr(CSR_TICLR, 32'h1);
        end_test("periodic timer", e0);

        e0 = errors;
        for (int i = 0; i < N_IRQ; i++) begin
            write_csr(CSR_ECFG, next_rand());
            write_csr(CSR_CRMD, next_rand());
            r = next_rand();
            @(posedge clk);
            hwi_i <= r[7:0];
            ipi_i <= r[8];
            @(posedge clk);
            @(negedge clk);
            checks++;
            if (irq_o !== ((|(m_ecfg & {r[8], m_tirq, 1'b0, r[7:0], m_is})) && m_crmd[2])) begin
                errors++;
                $display("Error at %0t: irq_o is %b after hwi_i %h", $time, irq_o, r[7:0]);
            end
        end
        end_test("interrupt output", e0);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
hw/csr_pkg.sv
hw/csr_priv_regs.sv
hw/csr_timer.sv
hw/csr_read_port.sv
hw/csr_top.sv
tb/csr_tb.sv
